// File: include/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// fetch and refill byte address
`define ICACHE_ADDR_W  32

// set index from address bits 8 to 3
`define ICACHE_INDEX_W 6
`define ICACHE_SETS    64

// tag from address bits 31 to 9
`define ICACHE_TAG_W   23

// one line holds two instruction words
`define ICACHE_LINE_W  64
`define ICACHE_INST_W  32

`define ICACHE_AGE_W   3

`endif

// File: verilog/icache_pkg.sv
package icache_pkg;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        LOOKUP = 2'd1,
        HIT    = 2'd2,
        REFILL = 2'd3
    } icache_state_e;

    typedef logic icache_way_t;

endpackage

// File: verilog/icache_tag_ram.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_tag_ram (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic [`ICACHE_INDEX_W-1:0] i_index,
    input  logic                       i_wr_en,
    input  logic [`ICACHE_TAG_W-1:0]   i_wr_tag,
    output logic [`ICACHE_TAG_W-1:0]   o_tag,
    output logic                       o_valid
);

    logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]  valid_q;

    // a write also shows up on the read port so the relookup after refill hits
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_mem[i_index] <= i_wr_tag;
            o_tag            <= i_wr_tag;
        end else begin
            o_tag <= tag_mem[i_index];
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            valid_q <= '0;
            o_valid <= 1'b0;
        end else if (i_wr_en) begin
            valid_q[i_index] <= 1'b1;
            o_valid          <= 1'b1;
        end else begin
            o_valid <= valid_q[i_index];
        end
    end

endmodule

// File: verilog/icache_data_ram.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_data_ram (
    input  logic                       clk,
    input  logic [`ICACHE_INDEX_W-1:0] i_index,
    input  logic                       i_wr_en,
    input  logic [`ICACHE_LINE_W-1:0]  i_wr_line,
    output logic [`ICACHE_LINE_W-1:0]  o_line
);

    logic [`ICACHE_LINE_W-1:0] line_mem [`ICACHE_SETS];

    // write-first, same as the tag array
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            line_mem[i_index] <= i_wr_line;
            o_line            <= i_wr_line;
        end else begin
            o_line <= line_mem[i_index];
        end
    end

endmodule

// File: verilog/icache_lru_age.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_lru_age (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic                       i_tick,
    input  logic                       i_touch_en,
    input  icache_pkg::icache_way_t    i_touch_way,
    input  logic [`ICACHE_INDEX_W-1:0] i_index,
    input  logic                       i_valid0,
    input  logic                       i_valid1,
    output icache_pkg::icache_way_t    o_victim_way
);

    import icache_pkg::*;

    logic [`ICACHE_AGE_W-1:0] age [2][`ICACHE_SETS];
    logic [`ICACHE_AGE_W-1:0] age0_cur;
    logic [`ICACHE_AGE_W-1:0] age1_cur;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < `ICACHE_SETS; s++) begin
                    age[w][s] <= '0;
                end
            end
        end else begin
            // saturating, every line ages on an accepted fetch
            if (i_tick) begin
                for (int w = 0; w < 2; w++) begin
                    for (int s = 0; s < `ICACHE_SETS; s++) begin
                        if (age[w][s] != '1) begin
                            age[w][s] <= age[w][s] + 1'b1;
                        end
                    end
                end
            end
            // later assignment, so a clear wins over the increment
            if (i_touch_en) begin
                age[i_touch_way][i_index] <= '0;
            end
        end
    end

    assign age0_cur = age[0][i_index];
    assign age1_cur = age[1][i_index];

    always_comb begin
        if (!i_valid0) begin
            o_victim_way = icache_way_t'(1'b0);
        end else if (!i_valid1) begin
            o_victim_way = icache_way_t'(1'b1);
        end else if (age0_cur >= age1_cur) begin
            // tie goes to way 0
            o_victim_way = icache_way_t'(1'b0);
        end else begin
            o_victim_way = icache_way_t'(1'b1);
        end
    end

endmodule

// File: verilog/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_ctrl (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic                       i_fetch_valid,
    input  logic [`ICACHE_ADDR_W-1:0]  i_fetch_addr,
    output logic                       o_fetch_ready,
    output logic                       o_inst_valid,
    output logic [`ICACHE_INST_W-1:0]  o_inst_data,
    input  logic                       i_inst_ready,
    output logic                       o_mem_req,
    output logic [`ICACHE_ADDR_W-1:0]  o_mem_addr,
    input  logic                       i_mem_valid,
    output logic [`ICACHE_INDEX_W-1:0] o_index,
    output logic [`ICACHE_TAG_W-1:0]   o_wr_tag,
    input  logic [`ICACHE_TAG_W-1:0]   i_tag0,
    input  logic                       i_valid0,
    input  logic [`ICACHE_TAG_W-1:0]   i_tag1,
    input  logic                       i_valid1,
    input  logic [`ICACHE_LINE_W-1:0]  i_line0,
    input  logic [`ICACHE_LINE_W-1:0]  i_line1,
    input  icache_pkg::icache_way_t    i_victim_way,
    output logic                       o_fill_en0,
    output logic                       o_fill_en1,
    output logic                       o_tick,
    output logic                       o_touch_en,
    output icache_pkg::icache_way_t    o_touch_way
);

    import icache_pkg::*;

    icache_state_e              state;
    icache_state_e              state_nxt;
    logic [`ICACHE_ADDR_W-1:0]  addr_q;
    logic [`ICACHE_TAG_W-1:0]   tag_q;
    icache_way_t                hit_way;
    logic [`ICACHE_LINE_W-1:0]  hit_line;
    logic                       accept;
    logic                       hit0;
    logic                       hit1;
    logic                       fill;
    logic                       inst_done;

    assign accept    = i_fetch_valid && o_fetch_ready;
    assign fill      = (state == REFILL) && i_mem_valid;
    assign inst_done = o_inst_valid && i_inst_ready;

    assign tag_q = addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign hit0  = i_valid0 && (i_tag0 == tag_q);
    assign hit1  = i_valid1 && (i_tag1 == tag_q);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (accept) state_nxt = LOOKUP;
            LOOKUP:  state_nxt = (hit0 || hit1) ? HIT : REFILL;
            HIT:     if (inst_done) state_nxt = IDLE;
            REFILL:  if (i_mem_valid) state_nxt = LOOKUP;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= i_fetch_addr;
        end
    end

    // way 0 wins if both ever matched
    always_ff @(posedge clk) begin
        if (state == LOOKUP) begin
            hit_way <= icache_way_t'(!hit0);
        end
    end

    // RAMs read the incoming set while idle, so data is ready in LOOKUP
    assign o_index = (state == IDLE) ? i_fetch_addr[3 +: `ICACHE_INDEX_W]
                                     : addr_q[3 +: `ICACHE_INDEX_W];

    assign o_fetch_ready = (state == IDLE);
    assign o_inst_valid  = (state == HIT);
    assign o_mem_req     = (state == REFILL);
    assign o_mem_addr    = {addr_q[`ICACHE_ADDR_W-1:3], 3'b000};
    assign o_wr_tag      = tag_q;

    assign hit_line    = (hit_way == 1'b1) ? i_line1 : i_line0;
    assign o_inst_data = addr_q[2] ? hit_line[`ICACHE_LINE_W-1 -: `ICACHE_INST_W]
                                   : hit_line[`ICACHE_INST_W-1:0];

    assign o_fill_en0 = fill && (i_victim_way == 1'b0);
    assign o_fill_en1 = fill && (i_victim_way == 1'b1);

    // age updates
    assign o_tick      = accept;
    assign o_touch_en  = fill || inst_done;
    assign o_touch_way = (state == REFILL) ? i_victim_way : hit_way;

endmodule

// File: verilog/icache_top.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_fetch_valid,
    input  logic [`ICACHE_ADDR_W-1:0] i_fetch_addr,
    output logic                      o_fetch_ready,
    output logic                      o_inst_valid,
    output logic [`ICACHE_INST_W-1:0] o_inst_data,
    input  logic                      i_inst_ready,
    output logic                      o_mem_req,
    output logic [`ICACHE_ADDR_W-1:0] o_mem_addr,
    input  logic                      i_mem_valid,
    input  logic [`ICACHE_LINE_W-1:0] i_mem_data
);

    import icache_pkg::*;

    logic [`ICACHE_INDEX_W-1:0] index;
    logic [`ICACHE_TAG_W-1:0]   wr_tag;
    logic [`ICACHE_TAG_W-1:0]   tag0;
    logic [`ICACHE_TAG_W-1:0]   tag1;
    logic                       valid0;
    logic                       valid1;
    logic [`ICACHE_LINE_W-1:0]  line0;
    logic [`ICACHE_LINE_W-1:0]  line1;
    logic                       fill_en0;
    logic                       fill_en1;
    logic                       tick;
    logic                       touch_en;
    icache_way_t                touch_way;
    icache_way_t                victim_way;

    icache_ctrl u_ctrl (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_fetch_valid (i_fetch_valid),
        .i_fetch_addr  (i_fetch_addr),
        .o_fetch_ready (o_fetch_ready),
        .o_inst_valid  (o_inst_valid),
        .o_inst_data   (o_inst_data),
        .i_inst_ready  (i_inst_ready),
        .o_mem_req     (o_mem_req),
        .o_mem_addr    (o_mem_addr),
        .i_mem_valid   (i_mem_valid),
        .o_index       (index),
        .o_wr_tag      (wr_tag),
        .i_tag0        (tag0),
        .i_valid0      (valid0),
        .i_tag1        (tag1),
        .i_valid1      (valid1),
        .i_line0       (line0),
        .i_line1       (line1),
        .i_victim_way  (victim_way),
        .o_fill_en0    (fill_en0),
        .o_fill_en1    (fill_en1),
        .o_tick        (tick),
        .o_touch_en    (touch_en),
        .o_touch_way   (touch_way)
    );

    icache_lru_age u_age (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_tick       (tick),
        .i_touch_en   (touch_en),
        .i_touch_way  (touch_way),
        .i_index      (index),
        .i_valid0     (valid0),
        .i_valid1     (valid1),
        .o_victim_way (victim_way)
    );

    icache_tag_ram u_tag0 (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_index  (index),
        .i_wr_en  (fill_en0),
        .i_wr_tag (wr_tag),
        .o_tag    (tag0),
        .o_valid  (valid0)
    );

    icache_tag_ram u_tag1 (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_index  (index),
        .i_wr_en  (fill_en1),
        .i_wr_tag (wr_tag),
        .o_tag    (tag1),
        .o_valid  (valid1)
    );

    // each way's fill enable goes to its own data array
    icache_data_ram u_data0 (
        .clk       (clk),
        .i_index   (index),
        .i_wr_en   (fill_en0),
        .i_wr_line (i_mem_data),
        .o_line    (line0)
    );

    icache_data_ram u_data1 (
        .clk       (clk),
        .i_index   (index),
        .i_wr_en   (fill_en1),
        .i_wr_line (i_mem_data),
        .o_line    (line1)
    );

endmodule

// File: sim/icache_checker.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_checker (
    input logic                      clk,
    input logic                      i_rst_n,
    input logic                      i_fetch_ready,
    input logic                      i_inst_valid,
    input logic [`ICACHE_INST_W-1:0] i_inst_data,
    input logic                      i_inst_ready,
    input logic                      i_mem_req,
    input logic [`ICACHE_ADDR_W-1:0] i_mem_addr,
    input logic                      i_mem_valid
);

    import icache_pkg::*;

    icache_state_e obs_state;
    int            assert_fails = 0;

    // controller state as seen from the ports, LOOKUP shows no output
    always_comb begin
        if (i_fetch_ready) begin
            obs_state = IDLE;
        end else if (i_inst_valid) begin
            obs_state = HIT;
        end else if (i_mem_req) begin
            obs_state = REFILL;
        end else begin
            obs_state = LOOKUP;
        end
    end

    ready_vs_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_fetch_ready && i_inst_valid))
        else begin
            $error("fetch ready and instruction valid are high together");
            assert_fails++;
        end

    inst_held: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_inst_valid && !i_inst_ready) |=> (i_inst_valid && $stable(i_inst_data)))
        else begin
            $error("instruction response changed under back-pressure");
            assert_fails++;
        end

    req_held: assert property (@(posedge clk) disable iff (!i_rst_n)
        (obs_state == REFILL && !i_mem_valid) |=> (obs_state == REFILL))
        else begin
            $error("refill request dropped before the line arrived");
            assert_fails++;
        end

    req_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_mem_req |-> (i_mem_addr[2:0] == 3'b000))
        else begin
            $error("refill address is not line aligned");
            assert_fails++;
        end

endmodule

bind icache_top icache_checker u_chk (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_fetch_ready (o_fetch_ready),
    .i_inst_valid  (o_inst_valid),
    .i_inst_data   (o_inst_data),
    .i_inst_ready  (i_inst_ready),
    .i_mem_req     (o_mem_req),
    .i_mem_addr    (o_mem_addr),
    .i_mem_valid   (i_mem_valid)
);

// File: sim/tb_icache_top.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module tb_icache_top;

    localparam int N_TESTS  = 8;
    localparam int MAX_WAIT = 60;

    logic                      clk;
    logic                      i_rst_n;
    logic                      i_fetch_valid;
    logic [`ICACHE_ADDR_W-1:0] i_fetch_addr;
    logic                      o_fetch_ready;
    logic                      o_inst_valid;
    logic [`ICACHE_INST_W-1:0] o_inst_data;
    logic                      i_inst_ready;
    logic                      o_mem_req;
    logic [`ICACHE_ADDR_W-1:0] o_mem_addr;
    logic                      i_mem_valid;
    logic [`ICACHE_LINE_W-1:0] i_mem_data;

    int          errors = 0;
    int          checks_run = 0;
    int          req_count = 0;
    logic [31:0] cur_addr = '0;
    logic [31:0] rng_state = 32'hc5c4;

    // set 0 warms up with one line, then tags a, b, c share set 5;
    // c evicts a (older way 0), b survives, so a misses again at the end
    string       tbl_name [N_TESTS] = '{"cold_low", "same_line_high", "set5_tag_a",
                                        "set5_tag_b", "set5_tag_c", "refetch_c",
                                        "refetch_b", "refetch_a_high"};
    logic [31:0] tbl_addr [N_TESTS] = '{32'h0000_1000, 32'h0000_1004, 32'h0000_0028,
                                        32'h0000_0228, 32'h0000_0428, 32'h0000_042c,
                                        32'h0000_022c, 32'h0000_002c};
    bit          tbl_miss [N_TESTS] = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
    int          tbl_hold [N_TESTS] = '{0, 4, 0, 0, 2, 0, 0, 3};

    icache_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // low word is the aligned address, high word its inverse
    function automatic logic [31:0] line_word(input logic [31:0] addr);
        logic [31:0] base;
        base = {addr[31:3], 3'b000};
        return addr[2] ? ~base : base;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks_run++;
        assert (expected === actual) else begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, MAX_WAIT);
        errors++;
    endtask

    // memory model answers each request after 1 to 6 cycles
    initial begin
        int delay;
        forever begin
            @(posedge clk);
            #1;
            if (o_mem_req) begin
                req_count++;
                check_value("mem_addr", {cur_addr[31:3], 3'b000}, o_mem_addr);
                rng_state = xorshift32(rng_state);
                delay = int'(rng_state % 32'd6) + 1;
                repeat (delay - 1) begin
                    @(posedge clk);
                    #1;
                end
                i_mem_valid = 1'b1;
                i_mem_data  = {~o_mem_addr, o_mem_addr};
                @(posedge clk);
                #1;
                i_mem_valid = 1'b0;
            end
        end
    end

    initial begin
        int          cycles;
        logic [31:0] held;
        string       name;
        i_rst_n       = 1'b0;
        i_fetch_valid = 1'b0;
        i_fetch_addr  = '0;
        i_inst_ready  = 1'b1;
        i_mem_valid   = 1'b0;
        i_mem_data    = '0;
        repeat (8) @(posedge clk);
        #1;
        i_rst_n = 1'b1;
        check_value("reset/fetch_ready", 32'd1, 32'(o_fetch_ready));
        check_value("reset/inst_valid", 32'd0, 32'(o_inst_valid));
        check_value("reset/mem_req", 32'd0, 32'(o_mem_req));

        for (int i = 0; i < N_TESTS; i++) begin
            name = tbl_name[i];
            cycles = 0;
            while (!o_fetch_ready && cycles < MAX_WAIT) begin
                @(posedge clk);
                #1;
                cycles++;
            end
            if (!o_fetch_ready) begin
                report_timeout({name, " fetch ready"});
                break;
            end
            cur_addr      = tbl_addr[i];
            req_count     = 0;
            i_fetch_valid = 1'b1;
            i_fetch_addr  = cur_addr;
            i_inst_ready  = (tbl_hold[i] == 0);
            @(posedge clk);
            #1;
            i_fetch_valid = 1'b0;
            cycles = 0;
            while (!o_inst_valid && cycles < MAX_WAIT) begin
                @(posedge clk);
                #1;
                cycles++;
            end
            if (!o_inst_valid) begin
                report_timeout({name, " instruction valid"});
                break;
            end
            check_value({name, "/mem_requests"}, 32'(tbl_miss[i]), 32'(req_count));
            if (!tbl_miss[i]) check_value({name, "/hit_latency"}, 32'd1, 32'(cycles));
            check_value({name, "/data"}, line_word(cur_addr), o_inst_data);
            held = o_inst_data;
            for (int h = 0; h < tbl_hold[i]; h++) begin
                @(posedge clk);
                #1;
                check_value({name, "/held_valid"}, 32'd1, 32'(o_inst_valid));
                check_value({name, "/held_data"}, held, o_inst_data);
                check_value({name, "/held_ready"}, 32'd0, 32'(o_fetch_ready));
            end
            i_inst_ready = 1'b1;
            @(posedge clk);
            #1;
            check_value({name, "/done_valid"}, 32'd0, 32'(o_inst_valid));
            check_value({name, "/done_ready"}, 32'd1, 32'(o_fetch_ready));
        end

        $display("checks run %0d, errors %0d, assertion failures %0d",
                 checks_run, errors, dut.u_chk.assert_fails);
        if (errors == 0 && dut.u_chk.assert_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: icache_top.f
+incdir+include
verilog/icache_pkg.sv
verilog/icache_tag_ram.sv
verilog/icache_data_ram.sv
verilog/icache_lru_age.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
sim/icache_checker.sv
sim/tb_icache_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f icache_top.f \
    --top-module tb_icache_top -Mdir obj_dir -o tb_icache_top
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_icache_top +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    exit 1
fi
exit 0
